//--- Makefile
TOOL       ?= verilator
TOP        ?= mmu_miss_tb
FLIST      ?= vlog.f
FLAGS      ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  := TEST RESULT: PASS

.PHONY: all run build lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/miss_req_buffer.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module miss_req_buffer #(
  parameter int ALLOC_WIDTH = `MMU_ALLOC_WIDTH
) (
  input  logic                                   clk,
  input  logic                                   rst_n_i,
  input  logic [ALLOC_WIDTH-1:0]                 enq_vld_i,
  input  mmu_pkg::miss_req_t [ALLOC_WIDTH-1:0]   enq_req_i,
  output logic                                   deq_vld_o,
  output mmu_pkg::miss_req_t                     deq_req_o,
  input  logic                                   deq_pop_i,
  output logic                                   full_o
);

  localparam int DEPTH = 2 * ALLOC_WIDTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  mmu_pkg::miss_req_t mem_q [DEPTH];
  logic [PTR_W-1:0]   slot [ALLOC_WIDTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   wr_ptr_d;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_d;
  logic [CNT_W-1:0]   cnt_q;
  logic [CNT_W-1:0]   enq_cnt;
  logic               pop;

  // Valid ports pack into consecutive slots, lowest port first
  always_comb begin
    int unsigned ofs;
    ofs = 0;
    for (int i = 0; i < ALLOC_WIDTH; i++) begin
      slot[i] = PTR_W'((32'(wr_ptr_q) + ofs) % DEPTH);
      if (enq_vld_i[i]) begin
        ofs = ofs + 1;
      end
    end
    enq_cnt = CNT_W'(ofs);
  end

  assign pop      = deq_pop_i & deq_vld_o;
  assign wr_ptr_d = PTR_W'((32'(wr_ptr_q) + 32'(enq_cnt)) % DEPTH);
  assign rd_ptr_d = PTR_W'((32'(rd_ptr_q) + 1) % DEPTH);

  always_ff @(posedge clk) begin
    for (int i = 0; i < ALLOC_WIDTH; i++) begin
      if (enq_vld_i[i]) begin
        mem_q[slot[i]] <= enq_req_i[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_d;
      if (pop) begin
        rd_ptr_q <= rd_ptr_d;
      end
      cnt_q <= cnt_q + enq_cnt - CNT_W'(pop);
    end
  end

  assign deq_vld_o = (cnt_q != '0);
  assign deq_req_o = mem_q[rd_ptr_q];

  // Not enough room left for a full row of misses
  assign full_o = (DEPTH - 32'(cnt_q)) < ALLOC_WIDTH;

endmodule

//--- logic/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// Field widths
`define MMU_VPN_W       27
`define MMU_PPN_W       20
`define MMU_ASID_W      16
`define MMU_TRANS_ID_W  3

// MSHR entries, at most 2**MMU_TRANS_ID_W
`define MMU_ENTRY_COUNT 4

// TLB miss ports
`define MMU_ALLOC_WIDTH 2

// Jobs held by the walker
`define MMU_WALK_DEPTH  2

`endif

//--- logic/mmu_miss_top.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmu_miss_top (
  input  logic                                       clk,
  input  logic                                       rst_n_i,
  input  logic [`MMU_ALLOC_WIDTH-1:0]                miss_vld_i,
  input  mmu_pkg::miss_req_t [`MMU_ALLOC_WIDTH-1:0]  miss_req_i,
  output logic                                       fill_vld_o,
  output mmu_pkg::tlb_fill_t                         fill_o,
  output logic                                       mem_req_vld_o,
  output mmu_pkg::mem_req_t                          mem_req_o,
  input  logic                                       mem_req_rdy_i,
  input  logic                                       mem_rsp_vld_i,
  input  logic [63:0]                                mem_rsp_pte_i,
  input  logic                                       csr_wr_i,
  input  logic                                       csr_addr_i,
  input  logic [31:0]                                csr_wdata_i,
  output logic                                       inflight_o
);

  logic                       head_vld;
  mmu_pkg::miss_req_t         head;
  logic                       head_pop;
  logic                       buf_full;
  logic                       grant_vld;
  mmu_pkg::miss_grant_t       grant;
  logic                       grant_rdy;
  logic                       dealloc_vld;
  logic [`MMU_TRANS_ID_W-1:0] dealloc_id;
  logic                       mshr_busy;
  logic [`MMU_PPN_W-1:0]      root_ppn;
  logic                       walk_en;

  miss_req_buffer #(
    .ALLOC_WIDTH(`MMU_ALLOC_WIDTH)
  ) u_miss_buf (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .enq_vld_i (miss_vld_i),
    .enq_req_i (miss_req_i),
    .deq_vld_o (head_vld),
    .deq_req_o (head),
    .deq_pop_i (head_pop),
    .full_o    (buf_full)
  );

  mmu_mshr #(
    .ENTRY_COUNT(`MMU_ENTRY_COUNT)
  ) u_mshr (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .head_vld_i    (head_vld),
    .head_i        (head),
    .head_pop_o    (head_pop),
    .walk_en_i     (walk_en),
    .grant_vld_o   (grant_vld),
    .grant_o       (grant),
    .grant_rdy_i   (grant_rdy),
    .dealloc_vld_i (dealloc_vld),
    .dealloc_id_i  (dealloc_id),
    .busy_o        (mshr_busy)
  );

  ptw_csr u_csr (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .csr_wr_i    (csr_wr_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .root_ppn_o  (root_ppn),
    .walk_en_o   (walk_en)
  );

  ptw_walker #(
    .DEPTH(`MMU_WALK_DEPTH)
  ) u_walker (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .grant_vld_i   (grant_vld),
    .grant_i       (grant),
    .grant_rdy_o   (grant_rdy),
    .root_ppn_i    (root_ppn),
    .mem_req_vld_o (mem_req_vld_o),
    .mem_req_o     (mem_req_o),
    .mem_req_rdy_i (mem_req_rdy_i),
    .mem_rsp_vld_i (mem_rsp_vld_i),
    .mem_rsp_pte_i (mem_rsp_pte_i),
    .fill_vld_o    (fill_vld_o),
    .fill_o        (fill_o),
    .dealloc_vld_o (dealloc_vld),
    .dealloc_id_o  (dealloc_id)
  );

  // Anything still on its way from a miss to a fill
  assign inflight_o = (|miss_vld_i) | head_vld | buf_full | mshr_busy | grant_vld;

endmodule

//--- logic/mmu_mshr.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmu_mshr #(
  parameter int ENTRY_COUNT = `MMU_ENTRY_COUNT
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       head_vld_i,
  input  mmu_pkg::miss_req_t         head_i,
  output logic                       head_pop_o,
  input  logic                       walk_en_i,
  output logic                       grant_vld_o,
  output mmu_pkg::miss_grant_t       grant_o,
  input  logic                       grant_rdy_i,
  input  logic                       dealloc_vld_i,
  input  logic [`MMU_TRANS_ID_W-1:0] dealloc_id_i,
  output logic                       busy_o
);

  localparam int ID_W = (ENTRY_COUNT > 1) ? $clog2(ENTRY_COUNT) : 1;

  logic [ENTRY_COUNT-1:0]  vld_q;
  logic [`MMU_VPN_W-1:0]   vpn_q [ENTRY_COUNT];
  logic [ENTRY_COUNT-1:0]  match;
  logic [ENTRY_COUNT-1:0]  free;
  logic [ENTRY_COUNT-1:0]  alloc_oh;
  logic [ENTRY_COUNT-1:0]  dealloc_oh;
  logic [ID_W-1:0]         alloc_id;
  logic                    waive;
  logic                    grant_fire;

  // Same VPN already being walked
  always_comb begin
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      match[i] = vld_q[i] & (vpn_q[i] == head_i.vpn);
    end
  end
  assign waive = |match;

  assign free     = ~vld_q;
  assign alloc_oh = free & (~free + 1'b1);

  always_comb begin
    alloc_id = '0;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (alloc_oh[i]) begin
        alloc_id = alloc_id | ID_W'(i);
      end
    end
  end

  assign grant_vld_o = head_vld_i & (|free) & walk_en_i & ~waive;
  assign grant_fire  = grant_vld_o & grant_rdy_i;
  assign head_pop_o  = head_vld_i & (grant_fire | waive);

  always_comb begin
    grant_o          = '0;
    grant_o.trans_id = `MMU_TRANS_ID_W'(alloc_id);
    grant_o.access   = head_i.access;
    grant_o.asid     = head_i.asid;
    grant_o.vpn      = head_i.vpn;
  end

  assign dealloc_oh = dealloc_vld_i ? (ENTRY_COUNT'(1) << dealloc_id_i[ID_W-1:0]) : '0;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= (vld_q & ~dealloc_oh) | (grant_fire ? alloc_oh : '0);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (grant_fire && alloc_oh[i]) begin
        vpn_q[i] <= head_i.vpn;
      end
    end
  end

  assign busy_o = |vld_q;

endmodule

//--- logic/mmu_pkg.sv
`include "mmu_consts.svh"

package mmu_pkg;

  typedef enum logic [1:0] {
    ACC_LOAD  = 2'd0,
    ACC_STORE = 2'd1,
    ACC_FETCH = 2'd2
  } access_e;

  // One TLB miss, 45 bits
  typedef struct packed {
    access_e                 access;
    logic [`MMU_ASID_W-1:0]  asid;
    logic [`MMU_VPN_W-1:0]   vpn;
  } miss_req_t;

  typedef struct packed {
    logic [`MMU_TRANS_ID_W-1:0] trans_id;
    access_e                    access;
    logic [`MMU_ASID_W-1:0]     asid;
    logic [`MMU_VPN_W-1:0]      vpn;
  } miss_grant_t;

  typedef struct packed {
    logic [`MMU_TRANS_ID_W-1:0] trans_id;
    logic [`MMU_ASID_W-1:0]     asid;
    logic [`MMU_VPN_W-1:0]      vpn;
    logic [`MMU_PPN_W-1:0]      ppn;
    access_e                    access;
    logic                       fault;
  } tlb_fill_t;

  typedef struct packed {
    logic [63:0]                addr;
    logic [`MMU_TRANS_ID_W-1:0] trans_id;
  } mem_req_t;

  typedef enum logic [1:0] {
    WALK_IDLE  = 2'd0,
    WALK_ISSUE = 2'd1,
    WALK_WAIT  = 2'd2,
    WALK_FILL  = 2'd3
  } walk_state_e;

endpackage

//--- logic/ptw_csr.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module ptw_csr (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  csr_wr_i,
  input  logic                  csr_addr_i,
  input  logic [31:0]           csr_wdata_i,
  output logic [`MMU_PPN_W-1:0] root_ppn_o,
  output logic                  walk_en_o
);

  localparam logic CSR_ROOT = 1'b0;
  localparam logic CSR_CTRL = 1'b1;

  logic [`MMU_PPN_W-1:0] root_ppn_q;
  logic                  walk_en_q;

  // Root page number of the flat table
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      root_ppn_q <= '0;
    end else if (csr_wr_i && csr_addr_i == CSR_ROOT) begin
      root_ppn_q <= csr_wdata_i[`MMU_PPN_W-1:0];
    end
  end

  // Walks enabled out of reset
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      walk_en_q <= 1'b1;
    end else if (csr_wr_i && csr_addr_i == CSR_CTRL) begin
      walk_en_q <= csr_wdata_i[0];
    end
  end

  assign root_ppn_o = root_ppn_q;
  assign walk_en_o  = walk_en_q;

endmodule

//--- logic/ptw_walker.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module ptw_walker #(
  parameter int DEPTH = `MMU_WALK_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       grant_vld_i,
  input  mmu_pkg::miss_grant_t       grant_i,
  output logic                       grant_rdy_o,
  input  logic [`MMU_PPN_W-1:0]      root_ppn_i,
  output logic                       mem_req_vld_o,
  output mmu_pkg::mem_req_t          mem_req_o,
  input  logic                       mem_req_rdy_i,
  input  logic                       mem_rsp_vld_i,
  input  logic [63:0]                mem_rsp_pte_i,
  output logic                       fill_vld_o,
  output mmu_pkg::tlb_fill_t         fill_o,
  output logic                       dealloc_vld_o,
  output logic [`MMU_TRANS_ID_W-1:0] dealloc_id_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  mmu_pkg::miss_grant_t job_q [DEPTH];
  mmu_pkg::miss_grant_t iss_job;
  mmu_pkg::miss_grant_t cmp_job;
  mmu_pkg::walk_state_e state_q;
  mmu_pkg::walk_state_e state_d;
  mmu_pkg::tlb_fill_t   fill_q;
  logic                 fill_vld_q;
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     iss_ptr_q;
  logic [PTR_W-1:0]     cmp_ptr_q;
  logic [CNT_W-1:0]     unissued_q;
  logic [CNT_W-1:0]     unissued_d;
  logic [CNT_W-1:0]     outst_q;
  logic [CNT_W-1:0]     outst_d;
  logic                 grant_fire;
  logic                 iss_fire;
  logic                 rsp_fire;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (32'(ptr) == DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // A slot frees on the response edge
  assign grant_rdy_o = (32'(unissued_q) + 32'(outst_q)) < DEPTH;
  assign grant_fire  = grant_vld_i & grant_rdy_o;
  assign iss_fire    = mem_req_vld_o & mem_req_rdy_i;
  assign rsp_fire    = mem_rsp_vld_i & (outst_q != '0);

  assign iss_job = job_q[iss_ptr_q];
  assign cmp_job = job_q[cmp_ptr_q];

  always_ff @(posedge clk) begin
    if (grant_fire) begin
      job_q[wr_ptr_q] <= grant_i;
    end
  end

  assign unissued_d = unissued_q + CNT_W'(grant_fire) - CNT_W'(iss_fire);
  assign outst_d    = outst_q + CNT_W'(iss_fire) - CNT_W'(rsp_fire);

  // Issue side state, registered so the request rises a cycle after the grant
  always_comb begin
    if (unissued_d != '0) begin
      state_d = mmu_pkg::WALK_ISSUE;
    end else if (outst_d != '0) begin
      state_d = mmu_pkg::WALK_WAIT;
    end else if (rsp_fire) begin
      state_d = mmu_pkg::WALK_FILL;
    end else begin
      state_d = mmu_pkg::WALK_IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= mmu_pkg::WALK_IDLE;
      wr_ptr_q   <= '0;
      iss_ptr_q  <= '0;
      cmp_ptr_q  <= '0;
      unissued_q <= '0;
      outst_q    <= '0;
      fill_vld_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      unissued_q <= unissued_d;
      outst_q    <= outst_d;
      fill_vld_q <= rsp_fire;
      if (grant_fire) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (iss_fire) begin
        iss_ptr_q <= ptr_inc(iss_ptr_q);
      end
      if (rsp_fire) begin
        cmp_ptr_q <= ptr_inc(cmp_ptr_q);
      end
    end
  end

  assign mem_req_vld_o = (state_q == mmu_pkg::WALK_ISSUE);

  // Leaf PTE at root page base plus 8 bytes per VPN
  always_comb begin
    mem_req_o          = '0;
    mem_req_o.addr     = (64'(root_ppn_i) << 12) + (64'(iss_job.vpn) << 3);
    mem_req_o.trans_id = iss_job.trans_id;
  end

  always_ff @(posedge clk) begin
    if (rsp_fire) begin
      fill_q.trans_id <= cmp_job.trans_id;
      fill_q.asid     <= cmp_job.asid;
      fill_q.vpn      <= cmp_job.vpn;
      fill_q.access   <= cmp_job.access;
      fill_q.ppn      <= mem_rsp_pte_i[10 +: `MMU_PPN_W];
      // Invalid PTE faults
      fill_q.fault    <= ~mem_rsp_pte_i[0];
    end
  end

  assign fill_vld_o    = fill_vld_q;
  assign fill_o        = fill_q;
  assign dealloc_vld_o = fill_vld_q;
  assign dealloc_id_o  = fill_q.trans_id;

endmodule

//--- tests/mmu_miss_tb.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmu_miss_tb;

  localparam int CYCLE_LIMIT = 4000;

  logic                                      clk;
  logic                                      rst_n_i;
  logic [`MMU_ALLOC_WIDTH-1:0]               miss_vld_i;
  mmu_pkg::miss_req_t [`MMU_ALLOC_WIDTH-1:0] miss_req_i;
  logic                                      fill_vld_o;
  mmu_pkg::tlb_fill_t                        fill_o;
  logic                                      mem_req_vld_o;
  mmu_pkg::mem_req_t                         mem_req_o;
  logic                                      mem_req_rdy_i;
  logic                                      mem_rsp_vld_i;
  logic [63:0]                               mem_rsp_pte_i;
  logic                                      csr_wr_i;
  logic                                      csr_addr_i;
  logic [31:0]                               csr_wdata_i;
  logic                                      inflight_o;

  // Scoreboard, keyed by VPN
  logic [15:0]      exp_asid [int];
  mmu_pkg::access_e exp_acc [int];
  int               read_cnt [int];
  int               fill_cnt [int];
  int               read_id [int];

  // Memory model, responses in request order
  logic [63:0] rsp_pte_q [$];
  int          rsp_due_q [$];
  int          rsp_id_q [$];

  int          cycle;
  int          err_cnt;
  int          chk_cnt;
  int          total_reads;
  int          total_fills;
  int          max_outst;
  int          last_fill_id;
  logic        last_fault;
  logic        rdy_hold;
  logic        inflight_s;
  logic [63:0] last_addr;
  logic [19:0] cur_root;

  mmu_miss_top UUT (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .miss_vld_i    (miss_vld_i),
    .miss_req_i    (miss_req_i),
    .fill_vld_o    (fill_vld_o),
    .fill_o        (fill_o),
    .mem_req_vld_o (mem_req_vld_o),
    .mem_req_o     (mem_req_o),
    .mem_req_rdy_i (mem_req_rdy_i),
    .mem_rsp_vld_i (mem_rsp_vld_i),
    .mem_rsp_pte_i (mem_rsp_pte_i),
    .csr_wr_i      (csr_wr_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .inflight_o    (inflight_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // PPN at bits 29:10, flag bits below with only V used
  function automatic logic [63:0] pte_for(input int vpn);
    logic valid;
    valid = (vpn[3:0] != 4'hF);
    return {34'b0, vpn[19:0] ^ 20'hA5A5A, 9'b0, valid};
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic note_error(input string msg);
    err_cnt++;
    $display("Error %0t: %s", $time, msg);
  endtask

  task automatic observe_fill();
    int vpn;
    if (fill_vld_o) begin
      vpn = int'(fill_o.vpn);
      total_fills++;
      last_fill_id = int'(fill_o.trans_id);
      last_fault = fill_o.fault;
      if (!exp_asid.exists(vpn) || read_cnt[vpn] == 0) begin
        note_error($sformatf("fill for VPN %h that was never read from memory", vpn));
      end else begin
        fill_cnt[vpn]++;
        check_val("fill_o.asid", 64'(fill_o.asid), 64'(exp_asid[vpn]));
        check_val("fill_o.access", 64'(fill_o.access), 64'(exp_acc[vpn]));
        check_val("fill_o.ppn", 64'(fill_o.ppn), 64'(vpn[19:0] ^ 20'hA5A5A));
        check_val("fill_o.fault", 64'(fill_o.fault), 64'(vpn[3:0] == 4'hF));
        check_val("fill_o.trans_id", 64'(fill_o.trans_id), 64'(read_id[vpn]));
      end
    end
  endtask

  task automatic serve_memory();
    int vpn;
    mem_rsp_vld_i = 1'b0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
      mem_rsp_vld_i = 1'b1;
      mem_rsp_pte_i = rsp_pte_q.pop_front();
      void'(rsp_due_q.pop_front());
      void'(rsp_id_q.pop_front());
    end
    mem_req_rdy_i = !rdy_hold;
    // Request fires on the coming rising edge
    if (mem_req_vld_o && mem_req_rdy_i) begin
      vpn = int'((mem_req_o.addr >> 3) - (64'(cur_root) << 9));
      if (mem_req_o.addr[2:0] != 3'b0 || !exp_asid.exists(vpn)) begin
        note_error($sformatf("memory read at %h matches no missed VPN", mem_req_o.addr));
      end else begin
        read_cnt[vpn]++;
        read_id[vpn] = int'(mem_req_o.trans_id);
      end
      foreach (rsp_id_q[i]) begin
        if (rsp_id_q[i] == int'(mem_req_o.trans_id)) begin
          note_error("two outstanding reads share a transaction ID");
        end
      end
      if (int'(mem_req_o.trans_id) >= `MMU_ENTRY_COUNT) begin
        note_error("transaction ID outside the MSHR range");
      end
      total_reads++;
      last_addr = mem_req_o.addr;
      rsp_pte_q.push_back(pte_for(vpn));
      rsp_due_q.push_back(cycle + 1 + int'($urandom % 6));
      rsp_id_q.push_back(int'(mem_req_o.trans_id));
      if (rsp_id_q.size() > max_outst) begin
        max_outst = rsp_id_q.size();
      end
    end
  endtask

  // One cycle, all sampling and driving at the falling edge
  task automatic tick();
    @(negedge clk);
    cycle++;
    if (cycle > CYCLE_LIMIT) begin
      $display("Timeout: no progress within %0d cycles, errors so far %0d", CYCLE_LIMIT, err_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      inflight_s = inflight_o;
      observe_fill();
      serve_memory();
      miss_vld_i = '0;
      csr_wr_i   = 1'b0;
    end
  endtask

  task automatic offer_miss(input int port, input int vpn, input logic [15:0] asid,
                            input mmu_pkg::access_e acc);
    if (!exp_asid.exists(vpn)) begin
      exp_asid[vpn] = asid;
      exp_acc[vpn]  = acc;
      read_cnt[vpn] = 0;
      fill_cnt[vpn] = 0;
    end
    miss_vld_i[port]        = 1'b1;
    miss_req_i[port].vpn    = `MMU_VPN_W'(vpn);
    miss_req_i[port].asid   = asid;
    miss_req_i[port].access = acc;
  endtask

  task automatic until_fills(input int n);
    while (total_fills < n) begin
      tick();
    end
  endtask

  task automatic drain(input int limit);
    int n;
    n = 0;
    tick();
    while (inflight_s && n < limit) begin
      tick();
      n++;
    end
    if (inflight_s) begin
      note_error("inflight_o still high long after the last fill");
    end
  endtask

  task automatic csr_write(input logic addr, input logic [31:0] data);
    tick();
    csr_wr_i    = 1'b1;
    csr_addr_i  = addr;
    csr_wdata_i = data;
    tick();
  endtask

  task automatic single_miss();
    int f0;
    f0 = total_fills;
    tick();
    offer_miss(0, 'h1234, 16'h00AB, mmu_pkg::ACC_LOAD);
    until_fills(f0 + 1);
    check_val("mem_req_o.addr", last_addr, (64'(cur_root) << 12) + (64'h1234 << 3));
    check_val("read count", 64'(read_cnt['h1234]), 1);
    drain(20);
  endtask

  task automatic same_vpn_merge();
    int f0;
    int r0;
    f0 = total_fills;
    r0 = total_reads;
    tick();
    offer_miss(0, 'h22A0, 16'h0011, mmu_pkg::ACC_STORE);
    offer_miss(1, 'h22A0, 16'h0011, mmu_pkg::ACC_STORE);
    while (read_cnt['h22A0] == 0) begin
      tick();
    end
    offer_miss(0, 'h22A0, 16'h0011, mmu_pkg::ACC_STORE);
    until_fills(f0 + 1);
    drain(40);
    check_val("memory reads", 64'(total_reads - r0), 1);
    check_val("fills", 64'(total_fills - f0), 1);
  endtask

  task automatic mshr_exhaustion();
    int vpns [4] = '{'h3001, 'h3102, 'h3203, 'h3304};
    int f0;
    int r0;
    f0 = total_fills;
    r0 = total_reads;
    max_outst = 0;
    rdy_hold = 1'b1;
    tick();
    offer_miss(0, vpns[0], 16'h0022, mmu_pkg::ACC_LOAD);
    offer_miss(1, vpns[1], 16'h0022, mmu_pkg::ACC_STORE);
    tick();
    offer_miss(0, vpns[2], 16'h0022, mmu_pkg::ACC_FETCH);
    offer_miss(1, vpns[3], 16'h0022, mmu_pkg::ACC_LOAD);
    repeat (20) tick();
    check_val("mem_req_vld_o", 64'(mem_req_vld_o), 1);
    check_val("inflight_o", 64'(inflight_s), 1);
    rdy_hold = 1'b0;
    // Only the jobs the walker took during the stall issue before a response
    until_fills(f0 + 1);
    check_val("reads before first fill", 64'(total_reads - r0), `MMU_WALK_DEPTH);
    until_fills(f0 + 4);
    if (max_outst > `MMU_WALK_DEPTH) begin
      note_error("more reads outstanding than the walker can hold");
    end
    foreach (vpns[i]) begin
      check_val("fill count", 64'(fill_cnt[vpns[i]]), 1);
    end
    drain(40);
    // All entries free again, so the lowest one is taken
    tick();
    offer_miss(0, 'h3405, 16'h0022, mmu_pkg::ACC_FETCH);
    until_fills(f0 + 5);
    check_val("fill_o.trans_id", 64'(last_fill_id), 0);
    drain(20);
  endtask

  task automatic faulting_pte();
    int f0;
    f0 = total_fills;
    tick();
    offer_miss(1, 'h345F, 16'h0044, mmu_pkg::ACC_FETCH);
    until_fills(f0 + 1);
    check_val("fill_o.fault", 64'(last_fault), 1);
    drain(20);
  endtask

  task automatic root_and_enable();
    int f0;
    int r0;
    csr_write(1'b0, 32'h123);
    cur_root = 20'h123;
    f0 = total_fills;
    tick();
    offer_miss(0, 'h4567, 16'h0033, mmu_pkg::ACC_LOAD);
    until_fills(f0 + 1);
    check_val("mem_req_o.addr", last_addr, (64'h123 << 12) + (64'h4567 << 3));
    drain(20);
    csr_write(1'b1, 32'h0);
    f0 = total_fills;
    r0 = total_reads;
    tick();
    offer_miss(0, 'h4568, 16'h0033, mmu_pkg::ACC_STORE);
    repeat (30) tick();
    check_val("reads with walks off", 64'(total_reads - r0), 0);
    check_val("fills with walks off", 64'(total_fills - f0), 0);
    csr_write(1'b1, 32'h1);
    until_fills(f0 + 1);
    check_val("read count", 64'(read_cnt['h4568]), 1);
    drain(20);
  endtask

  task automatic random_misses();
    int vpn_list [$];
    int sent;
    int group;
    int k;
    int vpn;
    int f0;
    f0 = total_fills;
    sent = 0;
    while (sent < 20) begin
      // At most four misses in the buffer at a time
      group = 0;
      while (group < 4 && sent < 20) begin
        tick();
        k = 1 + int'($urandom % 2);
        if (group + k > 4 || sent + k > 20) begin
          k = 1;
        end
        for (int p = 0; p < k; p++) begin
          do begin
            vpn = int'($urandom % (1 << `MMU_VPN_W));
          end while (exp_asid.exists(vpn));
          vpn_list.push_back(vpn);
          offer_miss(p, vpn, 16'($urandom), mmu_pkg::access_e'($urandom % 3));
        end
        group += k;
        sent += k;
      end
      until_fills(f0 + sent);
    end
    drain(40);
    foreach (vpn_list[i]) begin
      check_val("fill count", 64'(fill_cnt[vpn_list[i]]), 1);
    end
  endtask

  initial begin
    void'($urandom(50));
    rst_n_i       = 1'b0;
    miss_vld_i    = '0;
    miss_req_i    = '0;
    mem_req_rdy_i = 1'b1;
    mem_rsp_vld_i = 1'b0;
    mem_rsp_pte_i = '0;
    csr_wr_i      = 1'b0;
    csr_addr_i    = 1'b0;
    csr_wdata_i   = '0;
    cycle         = 0;
    err_cnt       = 0;
    chk_cnt       = 0;
    total_reads   = 0;
    total_fills   = 0;
    max_outst     = 0;
    last_fill_id  = 0;
    last_fault    = 1'b0;
    last_addr     = '0;
    rdy_hold      = 1'b0;
    cur_root      = '0;
    repeat (2) tick();
    rst_n_i = 1'b1;
    tick();
    check_val("fill_vld_o", 64'(fill_vld_o), 0);
    check_val("mem_req_vld_o", 64'(mem_req_vld_o), 0);
    check_val("inflight_o", 64'(inflight_s), 0);

    single_miss();
    same_vpn_merge();
    mshr_exhaustion();
    faulting_pte();
    root_and_enable();
    random_misses();

    // Every missed VPN read and filled exactly once
    foreach (exp_asid[v]) begin
      check_val($sformatf("read count of VPN %h", v), 64'(read_cnt[v]), 1);
      check_val($sformatf("fill count of VPN %h", v), 64'(fill_cnt[v]), 1);
    end

    $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+logic
logic/mmu_pkg.sv
logic/miss_req_buffer.sv
logic/mmu_mshr.sv
logic/ptw_csr.sv
logic/ptw_walker.sv
logic/mmu_miss_top.sv
tests/mmu_miss_tb.sv
